// File: source/dp_glue_pkg.sv
// ##################################################
// Shared definitions for the DP board glue logic
// Link sizes, PIO word widths, lane maps and the
// symbol, channel, status and control word types
// ##################################################

package dp_glue_pkg;

    // Link and video
    localparam int LANES = 4;
    localparam int SPL   = 4;                       // Symbols per lane
    localparam int PPC   = 4;                       // Pixels per clock
    localparam int BPC   = 10;                      // Bits per component

    localparam int RST_CNT_W     = 10;              // 1024 clock hold
    localparam int HB_BEAT       = 50;
    localparam int HB_CNT_W      = $clog2(HB_BEAT);
    localparam int PHY_PIO_IN_W  = 6;
    localparam int PHY_PIO_OUT_W = 19;
    localparam int APP_PIO_IN_W  = 4;
    localparam int APP_PIO_OUT_W = 3;

    // Crossed lane order of the board, entry 0 in the low bits
    localparam logic [LANES-1:0][1:0] TX_LANE_OF_CHAN = {2'd0, 2'd2, 2'd1, 2'd3};
    localparam logic [LANES-1:0][1:0] RX_CHAN_OF_LANE = {2'd3, 2'd1, 2'd2, 2'd0};

    typedef struct packed {
        logic       disp_mode;                      // 0 automatic, 1 forced
        logic       disp_val;                       // 0 negative, 1 positive
        logic       k;
        logic [7:0] dat;
    } tx_sym_t;

    typedef struct packed {
        logic       k;
        logic [7:0] dat;
    } rx_sym_t;

    typedef tx_sym_t [LANES-1:0][SPL-1:0] dptx_lnk_t;
    typedef rx_sym_t [LANES-1:0][SPL-1:0] dprx_lnk_t;

    // GT channel words, symbol s in byte s and flag bit s
    typedef struct packed {
        logic [SPL-1:0]   disp_mode;
        logic [SPL-1:0]   disp_val;
        logic [SPL-1:0]   k;
        logic [8*SPL-1:0] dat;
    } gt_tx_chan_t;

    typedef struct packed {
        logic [SPL-1:0]   k;
        logic [8*SPL-1:0] dat;
    } gt_rx_chan_t;

    typedef gt_tx_chan_t [LANES-1:0] gt_tx_t;
    typedef gt_rx_chan_t [LANES-1:0] gt_rx_t;

    typedef struct packed {
        logic       rxpll_lock;
        logic       txpll_lock;
        logic [1:0] gtpll_lock;
        logic       rx_rst_done;
        logic       tx_rst_done;
    } phy_status_t;

    typedef struct packed {
        logic [2:0] rx_rate;
        logic [2:0] tx_rate;
        logic [4:0] tx_postcursor;
        logic [3:0] tx_diffctrl;
        logic       rxpll_rst;
        logic       txpll_rst;
        logic       gtrx_rst;
        logic       gttx_rst;
    } phy_ctl_t;

    typedef struct packed {
        logic vid_clk_lock;
        logic gt_clk_lock;
    } board_status_t;

    typedef struct packed {
        logic dprx_rst;
        logic dptx_rst;
        logic clk_sel;
    } board_ctl_t;

    // Control values while the core is in reset
    localparam phy_ctl_t   PHY_CTL_RST   = phy_ctl_t'(19'h0000f);
    localparam board_ctl_t BOARD_CTL_RST = board_ctl_t'(3'b110);

endpackage

// File: source/reset_sequencer.sv
// ##################################################
// Core reset generator
// Keeps core_rst asserted for 1024 clocks after the
// external reset is released
// ##################################################

`timescale 1ns/10ps

module reset_sequencer
    import dp_glue_pkg::*;
(
    input  logic clk_por,
    input  logic sys_clk_from_pll,                  // External reset, active high
    output logic core_rst
);

    logic [RST_CNT_W-1:0] rst_cnt;

    always_ff @(posedge clk_por or posedge sys_clk_from_pll)
    begin
        if (sys_clk_from_pll)
        begin
            rst_cnt  <= '0;
            core_rst <= 1'b1;
        end
        else
        begin
            // Count up, then hold at all ones
            if (!(&rst_cnt))
            begin
                rst_cnt <= rst_cnt + RST_CNT_W'(1);
            end
            else
            begin
                core_rst <= 1'b0;                   // Released one edge after saturation
            end
        end
    end

endmodule

// File: source/gt_lane_router.sv
// ##################################################
// Lane router between the DP cores and the GT
// Moves DP lane symbols into GT channel words and
// back, following the crossed lane order of the board
// Both directions have one register stage
// ##################################################

`timescale 1ns/10ps

module gt_lane_router
    import dp_glue_pkg::*;
(
    input  logic      clk_por,
    input  logic      core_rst,
    input  dptx_lnk_t dptx_lnk,
    output gt_tx_t    gt_tx,
    input  gt_rx_t    gt_rx,
    output dprx_lnk_t dprx_lnk
);

    gt_tx_t    gt_tx_map;
    dprx_lnk_t dprx_map;

    // Transmit side, each channel picks its source lane
    always_comb
    begin
        for (int c = 0; c < LANES; c++)
        begin
            for (int s = 0; s < SPL; s++)
            begin
                gt_tx_map[c].dat[8*s +: 8]  = dptx_lnk[TX_LANE_OF_CHAN[c]][s].dat;
                gt_tx_map[c].k[s]           = dptx_lnk[TX_LANE_OF_CHAN[c]][s].k;
                gt_tx_map[c].disp_val[s]    = dptx_lnk[TX_LANE_OF_CHAN[c]][s].disp_val;
                gt_tx_map[c].disp_mode[s]   = dptx_lnk[TX_LANE_OF_CHAN[c]][s].disp_mode;
            end
        end
    end

    // Receive side, channel word split back into symbols
    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            for (int s = 0; s < SPL; s++)
            begin
                dprx_map[l][s].dat = gt_rx[RX_CHAN_OF_LANE[l]].dat[8*s +: 8];
                dprx_map[l][s].k   = gt_rx[RX_CHAN_OF_LANE[l]].k[s];
            end
        end
    end

    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
        begin
            gt_tx    <= '0;                         // Idle link while in reset
            dprx_lnk <= '0;
        end
        else
        begin
            gt_tx    <= gt_tx_map;
            dprx_lnk <= dprx_map;
        end
    end

endmodule

// File: source/pio_bridge.sv
// ##################################################
// PIO bridge for the PHY and application controllers
// Status bits pass a two-flop synchronizer into the
// PIO input words; PIO output words are registered
// into the PHY and board control fields
// ##################################################

`timescale 1ns/10ps

module pio_bridge
    import dp_glue_pkg::*;
(
    input  logic                     clk_por,
    input  logic                     core_rst,
    input  phy_status_t              phy_status,
    input  board_status_t            board_status,
    output logic [PHY_PIO_IN_W-1:0]  phy_pio_in,
    output logic [APP_PIO_IN_W-1:0]  app_pio_in,
    input  logic [PHY_PIO_OUT_W-1:0] phy_pio_out,
    input  logic [APP_PIO_OUT_W-1:0] app_pio_out,
    output phy_ctl_t                 phy_ctl,
    output board_ctl_t               board_ctl
);

    localparam int SYNC_W = $bits(board_status_t) + $bits(phy_status_t);

    // Fixed design options reported to the application
    localparam logic PPC_IS_4  = (PPC == 4);
    localparam logic BPC_IS_10 = (BPC == 10);

    logic [SYNC_W-1:0] meta_q;                      // First synchronizer stage
    logic [SYNC_W-1:0] sync_q;
    board_status_t     board_sync;

    // All status bits share one synchronizer
    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
        begin
            meta_q <= '0;
            sync_q <= '0;
        end
        else
        begin
            meta_q <= {board_status, phy_status};
            sync_q <= meta_q;
        end
    end

    assign board_sync = board_status_t'(sync_q[SYNC_W-1 -: $bits(board_status_t)]);

    assign phy_pio_in = sync_q[PHY_PIO_IN_W-1:0];   // Same order as phy_status_t
    assign app_pio_in = {board_sync.vid_clk_lock, board_sync.gt_clk_lock, BPC_IS_10, PPC_IS_4};

    // Control decode, bit for bit into the field order
    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
        begin
            phy_ctl   <= PHY_CTL_RST;               // GT and PLL resets held
            board_ctl <= BOARD_CTL_RST;             // DP cores held in reset
        end
        else
        begin
            phy_ctl   <= phy_ctl_t'(phy_pio_out);
            board_ctl <= board_ctl_t'(app_pio_out);
        end
    end

endmodule

// File: source/heartbeat.sv
// ##################################################
// System heartbeat LED
// Toggles hb_led once every HB_BEAT clocks
// ##################################################

`timescale 1ns/10ps

module heartbeat
    import dp_glue_pkg::*;
(
    input  logic clk_por,
    input  logic core_rst,
    output logic hb_led
);

    logic [HB_CNT_W-1:0] beat_cnt;

    always_ff @(posedge clk_por or posedge core_rst)
    begin
        if (core_rst)
        begin
            beat_cnt <= '0;
            hb_led   <= 1'b0;
        end
        else if (beat_cnt == HB_CNT_W'(HB_BEAT - 1))
        begin
            beat_cnt <= '0;                         // Restart and flip the LED
            hb_led   <= ~hb_led;
        end
        else
        begin
            beat_cnt <= beat_cnt + HB_CNT_W'(1);
        end
    end

endmodule

// File: source/dp_glue_top.sv
// ##################################################
// Board glue top level of the DP reference design
// Joins reset sequencing, GT lane routing, the PIO
// bridge and the heartbeat, all on clk_por
// ##################################################

`timescale 1ns/10ps

module dp_glue_top
    import dp_glue_pkg::*;
(
    input  logic                     clk_por,
    input  logic                     sys_clk_from_pll,
    input  dptx_lnk_t                dptx_lnk,
    input  gt_rx_t                   gt_rx,
    input  phy_status_t              phy_status,
    input  board_status_t            board_status,
    input  logic [PHY_PIO_OUT_W-1:0] phy_pio_out,
    input  logic [APP_PIO_OUT_W-1:0] app_pio_out,
    output logic                     core_rst,
    output gt_tx_t                   gt_tx,
    output dprx_lnk_t                dprx_lnk,
    output logic [PHY_PIO_IN_W-1:0]  phy_pio_in,
    output logic [APP_PIO_IN_W-1:0]  app_pio_in,
    output phy_ctl_t                 phy_ctl,
    output board_ctl_t               board_ctl,
    output logic                     hb_led
);

    // Core reset for everything below
    reset_sequencer u_reset_sequencer
    (
        .clk_por          (clk_por),
        .sys_clk_from_pll (sys_clk_from_pll),
        .core_rst         (core_rst)
    );

    gt_lane_router u_gt_lane_router
    (
        .clk_por  (clk_por),
        .core_rst (core_rst),
        .dptx_lnk (dptx_lnk),               // From DP transmitter
        .gt_tx    (gt_tx),
        .gt_rx    (gt_rx),                  // From GT receiver
        .dprx_lnk (dprx_lnk)
    );

    // PHY and application controller PIO
    pio_bridge u_pio_bridge
    (
        .clk_por      (clk_por),
        .core_rst     (core_rst),
        .phy_status   (phy_status),
        .board_status (board_status),
        .phy_pio_in   (phy_pio_in),
        .app_pio_in   (app_pio_in),
        .phy_pio_out  (phy_pio_out),
        .app_pio_out  (app_pio_out),
        .phy_ctl      (phy_ctl),
        .board_ctl    (board_ctl)
    );

    heartbeat u_heartbeat
    (
        .clk_por  (clk_por),
        .core_rst (core_rst),
        .hb_led   (hb_led)                  // System LED
    );

endmodule

// File: dv/dp_glue_asserts.sv
// ##################################################
// Concurrent assertions on the DP glue top level
// Bound into dp_glue_top from this file
// ##################################################

`timescale 1ns/10ps

module dp_glue_asserts
    import dp_glue_pkg::*;
(
    input logic       clk_por,
    input logic       sys_clk_from_pll,
    input logic       core_rst,
    input board_ctl_t board_ctl,
    input gt_tx_t     gt_tx
);

    // External reset always forces the core reset
    assert property (@(posedge clk_por) sys_clk_from_pll |-> core_rst)
        else $error("core_rst low while external reset is high");

    assert property (@(posedge clk_por) core_rst |-> (board_ctl.dptx_rst && board_ctl.dprx_rst))
        else $error("DP core resets released while core_rst is high");

    assert property (@(posedge clk_por) core_rst |=> (gt_tx == '0))
        else $error("gt_tx not idle after core_rst");

endmodule

bind dp_glue_top dp_glue_asserts u_dp_glue_asserts
(
    .clk_por          (clk_por),
    .sys_clk_from_pll (sys_clk_from_pll),
    .core_rst         (core_rst),
    .board_ctl        (board_ctl),
    .gt_tx            (gt_tx)
);

// File: dv/dp_glue_checker.sv
// ##################################################
// Reference model and checker for the DP glue top
// Samples all ports on the falling clock edge and
// compares them with delayed input copies
// ##################################################

`timescale 1ns/10ps

module dp_glue_checker
    import dp_glue_pkg::*;
(
    input logic          clk_por,
    input logic          sys_clk_from_pll,
    input dptx_lnk_t     dptx_lnk,
    input gt_rx_t        gt_rx,
    input phy_status_t   phy_status,
    input board_status_t board_status,
    input logic [18:0]   phy_pio_out,
    input logic [2:0]    app_pio_out,
    input logic          core_rst,
    input gt_tx_t        gt_tx,
    input dprx_lnk_t     dprx_lnk,
    input logic [5:0]    phy_pio_in,
    input logic [3:0]    app_pio_in,
    input phy_ctl_t      phy_ctl,
    input board_ctl_t    board_ctl,
    input logic          hb_led
);

    int err_total = 0;
    int chk_total = 0;
    int err_test  = 0;
    int chk_test  = 0;
    int tests     = 0;
    int rel_edges = 0;                              // Edges since external release
    int rel       = 0;                              // Cycles since core_rst fell

    int tx_lane[4] = '{3, 1, 2, 0};                 // Board lane crossing
    int rx_chan[4] = '{0, 2, 1, 3};

    logic [175:0] dptx_q;
    logic [143:0] gt_rx_q;
    logic [21:0]  pio_q;
    logic [7:0]   sta_q1;
    logic [7:0]   sta_q2;
    logic         exp_hb;

    function automatic logic [175:0] tx_model(logic [175:0] lnk);
        logic [175:0] w;
        int           b;
        w = '0;
        for (int c = 0; c < 4; c++)
        begin
            for (int s = 0; s < 4; s++)
            begin
                b = (tx_lane[c] * 4 + s) * 11;
                w[c*44 + 8*s +: 8] = lnk[b +: 8];
                w[c*44 + 32 + s]   = lnk[b + 8];
                w[c*44 + 36 + s]   = lnk[b + 9];
                w[c*44 + 40 + s]   = lnk[b + 10];
            end
        end
        return w;
    endfunction

    function automatic logic [143:0] rx_model(logic [143:0] gt);
        logic [143:0] w;
        int           b;
        w = '0;
        for (int l = 0; l < 4; l++)
        begin
            for (int s = 0; s < 4; s++)
            begin
                b = (l * 4 + s) * 9;
                w[b +: 8] = gt[rx_chan[l]*36 + 8*s +: 8];
                w[b + 8]  = gt[rx_chan[l]*36 + 32 + s];
            end
        end
        return w;
    endfunction

    task automatic check_val(string name, logic [175:0] exp_v, logic [175:0] act_v);
        chk_test++;
        chk_total++;
        if (act_v !== exp_v)
        begin
            $display("Fail %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
            err_test++;
            err_total++;
        end
    endtask

    task automatic report_test(string name);
        tests++;
        $display("Test %s: %0d checks, %0d errors", name, chk_test, err_test);
        chk_test = 0;
        err_test = 0;
    endtask

    task automatic report_totals();
        $display("Totals: %0d tests, %0d checks, %0d errors", tests, chk_total, err_total);
    endtask

    always @(negedge clk_por)
    begin
        if (sys_clk_from_pll)
            rel_edges = 0;
        else if (rel_edges < 5000)
            rel_edges++;
        check_val("core_rst", {175'd0, sys_clk_from_pll || rel_edges < 1025}, {175'd0, core_rst});
        check_val("app_pio_in[1:0]", 176'h3, {174'd0, app_pio_in[1:0]});

        if (core_rst)
        begin
            check_val("phy_ctl", 176'h0000f, {157'd0, phy_ctl});
            check_val("board_ctl", 176'h6, {173'd0, board_ctl});
            check_val("hb_led", '0, {175'd0, hb_led});
            check_val("gt_tx", '0, gt_tx);
            check_val("dprx_lnk", '0, {32'd0, dprx_lnk});
            rel    = 0;
            exp_hb = 1'b0;
        end
        else
        begin
            if (rel >= 1)
            begin
                check_val("gt_tx", tx_model(dptx_q), gt_tx);
                check_val("dprx_lnk", {32'd0, rx_model(gt_rx_q)}, {32'd0, dprx_lnk});
                check_val("phy_ctl", {157'd0, pio_q[18:0]}, {157'd0, phy_ctl});
                check_val("board_ctl", {173'd0, pio_q[21:19]}, {173'd0, board_ctl});
            end
            if (rel >= 2)
            begin
                check_val("phy_pio_in", {170'd0, sta_q2[5:0]}, {170'd0, phy_pio_in});
                check_val("app_pio_in[3:2]", {174'd0, sta_q2[7:6]}, {174'd0, app_pio_in[3:2]});
            end
            if (rel > 0 && rel % 50 == 0)
                exp_hb = ~exp_hb;
            check_val("hb_led", {175'd0, exp_hb}, {175'd0, hb_led});
            if (rel < 100000)
                rel++;
        end

        dptx_q  = dptx_lnk;
        gt_rx_q = gt_rx;
        pio_q   = {app_pio_out, phy_pio_out};
        sta_q2  = sta_q1;
        sta_q1  = {board_status, phy_status};
    end

endmodule

// File: dv/tb_dp_glue.sv
// ##################################################
// Testbench for the DP board glue top level
// Drives LFSR random stimulus test by test; the
// checker module does all the comparing
// ##################################################

`timescale 1ns/10ps

module tb_dp_glue
    import dp_glue_pkg::*;
;

    logic                     clk_por;
    logic                     sys_clk_from_pll;
    dptx_lnk_t                dptx_lnk;
    gt_rx_t                   gt_rx;
    phy_status_t              phy_status;
    board_status_t            board_status;
    logic [PHY_PIO_OUT_W-1:0] phy_pio_out;
    logic [APP_PIO_OUT_W-1:0] app_pio_out;
    logic                     core_rst;
    gt_tx_t                   gt_tx;
    dprx_lnk_t                dprx_lnk;
    logic [PHY_PIO_IN_W-1:0]  phy_pio_in;
    logic [APP_PIO_IN_W-1:0]  app_pio_in;
    phy_ctl_t                 phy_ctl;
    board_ctl_t               board_ctl;
    logic                     hb_led;

    logic [15:0]  lfsr_state;
    logic [175:0] rnd;

    dp_glue_top dut (.*);

    dp_glue_checker chk (.*);

    // Fibonacci LFSR on taps 16 14 13 11
    function automatic logic step_lfsr();
        logic fb;
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [175:0] draw_rand(int n);
        logic [175:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v[i] = step_lfsr();
        end
        return v;
    endfunction

    task automatic stop_on_timeout(string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    initial
    begin
        clk_por = 1'b0;
        forever #4 clk_por = ~clk_por;
    end

    initial
    begin
        int   cycles;
        int   toggles;
        int   hold;
        logic last_hb;
        lfsr_state       = 16'd97;
        sys_clk_from_pll = 1'b1;
        dptx_lnk         = '0;
        gt_rx            = '0;
        phy_status       = '0;
        board_status     = '0;
        phy_pio_out      = '0;
        app_pio_out      = '0;

        repeat (4) @(posedge clk_por);
        sys_clk_from_pll <= 1'b0;
        cycles = 0;
        while (core_rst !== 1'b0)                   // 1024 clock hold
        begin
            @(posedge clk_por);
            dptx_lnk <= draw_rand($bits(dptx_lnk_t));   // Link traffic must stay blocked
            rnd = draw_rand($bits(gt_rx_t));
            gt_rx <= rnd[$bits(gt_rx_t)-1:0];
            cycles++;
            if (cycles > 1200)
                stop_on_timeout("core_rst release");
        end
        repeat (2) @(posedge clk_por);
        chk.report_test("reset sequence");

        for (int i = 0; i < 200; i++)
        begin
            @(posedge clk_por);
            dptx_lnk <= draw_rand($bits(dptx_lnk_t));
        end
        repeat (2) @(posedge clk_por);
        chk.report_test("transmit routing");

        for (int i = 0; i < 200; i++)
        begin
            @(posedge clk_por);
            rnd = draw_rand($bits(gt_rx_t));
            gt_rx <= rnd[$bits(gt_rx_t)-1:0];
        end
        repeat (2) @(posedge clk_por);
        chk.report_test("receive routing");

        // Each status value held 3 or 4 cycles
        for (int i = 0; i < 50; i++)
        begin
            @(posedge clk_por);
            rnd = draw_rand(9);
            phy_status   <= rnd[5:0];
            board_status <= rnd[7:6];
            hold = rnd[8] ? 3 : 2;
            repeat (hold) @(posedge clk_por);
        end
        repeat (3) @(posedge clk_por);
        chk.report_test("status synchronization");

        for (int i = 0; i < 200; i++)
        begin
            @(posedge clk_por);
            rnd = draw_rand(22);
            phy_pio_out <= rnd[18:0];
            app_pio_out <= rnd[21:19];
        end
        repeat (2) @(posedge clk_por);
        chk.report_test("control decode");

        toggles = 0;
        cycles  = 0;
        last_hb = hb_led;
        while (toggles < 5)
        begin
            @(posedge clk_por);
            cycles++;
            if (hb_led !== last_hb)
                toggles++;
            last_hb = hb_led;
            if (cycles > 6 * HB_BEAT)
                stop_on_timeout("heartbeat toggles");
        end
        chk.report_test("heartbeat");

        chk.report_totals();
        if (chk.err_total == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: files.f
source/dp_glue_pkg.sv
source/reset_sequencer.sv
source/gt_lane_router.sv
source/pio_bridge.sv
source/heartbeat.sv
source/dp_glue_top.sv
dv/dp_glue_asserts.sv
dv/dp_glue_checker.sv
dv/tb_dp_glue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DP glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_dp_glue -o sim_dp_glue

# Keep going after a nonzero simulator exit so the log decides
./obj_dir/sim_dp_glue > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    exit 1
fi
exit 0
